/* logic/fpAddPkg.sv */
//**********************************************************
// Shared types and constants of the binary64 add/sub pipeline
// Every block refers to these by scoped name
//**********************************************************
package fpAddPkg;

   // Operation select carried on opCode
   typedef enum logic {
      opAdd = 1'b0,
      opSub = 1'b1
   } fpOp;

   // Occupancy of the two-entry input buffer
   typedef enum logic [1:0] {
      sEmpty = 2'd0,
      sReady = 2'd1,
      sFull  = 2'd2
   } ctrlState;

   // IEEE-754 binary64 field widths
   localparam int EXP_W    = 11;
   localparam int MANT_W   = 52;
   localparam int WORD_W   = 1 + EXP_W + MANT_W;
   localparam int EXP_BIAS = 1023;

   // All-ones exponent, shared by infinity and NaN
   localparam logic [EXP_W-1:0] EXP_INF = EXP_W'(2 * EXP_BIAS + 1);
   // Lowest effective exponent, subnormals use it too
   localparam logic [EXP_W-1:0] EXP_MIN = EXP_W'(1);

   // Stage-1 significand: carry, hidden, fraction, guard, sticky
   localparam int SIG_W = MANT_W + 4;
   // Alignment adder: carry, hidden, fraction, guard, round, sticky
   localparam int SUM_W = MANT_W + 5;

   // Credit flow control
   localparam int                  IN_CREDITS  = 2;
   localparam int                  CREDIT_W    = 3;
   localparam logic [CREDIT_W-1:0] OUT_CREDITS = CREDIT_W'(4);

   // Bit positions in the flags port
   localparam int FLAG_W        = 2;
   localparam int FLAG_INVALID  = 0;
   localparam int FLAG_OVERFLOW = 1;

   // Canonical quiet NaN, positive, only the quiet bit set
   localparam logic [WORD_W-1:0] QNAN = 64'h7FF8_0000_0000_0000;

endpackage

/* logic/creditCounter.sv */
`timescale 1ns/1ps
//**********************************************************
// Output credit counter, loaded with OUT_CREDITS at reset
// One credit spent per sent result, one regained per resCredit
//**********************************************************
module creditCounter (
   input  logic clk,
   input  logic reset,
   input  logic sent,
   input  logic resCredit,
   output logic haveCredit
);

   // Credits the DUT may still spend
   logic [fpAddPkg::CREDIT_W-1:0] count;

   always_ff @(posedge clk) begin
      if (reset) begin
         count <= fpAddPkg::OUT_CREDITS;
      end else begin
         case ({sent, resCredit})
            2'b10: begin
               // Never wraps below zero
               if (count != '0) begin
                  count <= count - 1'b1;
               end
            end
            2'b01: begin
               // Never climbs past the initial allotment
               if (count != fpAddPkg::OUT_CREDITS) begin
                  count <= count + 1'b1;
               end
            end
            // Spend and return in the same cycle cancel out
            default: count <= count;
         endcase
      end
   end

   assign haveCredit = (count != '0);

endmodule

/* logic/fpAddControl.sv */
`timescale 1ns/1ps
//**********************************************************
// Input side control: two-entry buffer, issue and stall logic
// One input credit goes back to the producer per issued entry
//**********************************************************
module fpAddControl (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        opValid,
   input  fpAddPkg::fpOp               opCode,
   input  logic [fpAddPkg::WORD_W-1:0] opA,
   input  logic [fpAddPkg::WORD_W-1:0] opB,
   input  logic                        haveCredit,
   input  logic                        s2Valid,
   output logic                        inCredit,
   output logic                        issueValid,
   output fpAddPkg::fpOp               issueOp,
   output logic [fpAddPkg::WORD_W-1:0] issueA,
   output logic [fpAddPkg::WORD_W-1:0] issueB,
   output logic                        advance
);

   fpAddPkg::ctrlState state;
   fpAddPkg::ctrlState stateNext;

   // Circular buffer, one slot per producer credit
   fpAddPkg::fpOp               bufOp [fpAddPkg::IN_CREDITS];
   logic [fpAddPkg::WORD_W-1:0] bufA  [fpAddPkg::IN_CREDITS];
   logic [fpAddPkg::WORD_W-1:0] bufB  [fpAddPkg::IN_CREDITS];

   // One-bit pointers for the two slots
   logic wrPtr;
   logic rdPtr;
   logic push;
   logic pop;

   // Pipeline freezes only when a finished result has no output credit
   assign advance = !(s2Valid && !haveCredit);

   // Producer credits guarantee a free slot for every push
   assign push = opValid;
   assign pop  = advance && (state != fpAddPkg::sEmpty);

   // Oldest entry goes straight into stage 1
   assign issueValid = pop;
   assign issueOp    = bufOp[rdPtr];
   assign issueA     = bufA[rdPtr];
   assign issueB     = bufB[rdPtr];
   assign inCredit   = pop;

   // Occupancy tracking
   always_comb begin
      stateNext = state;
      case (state)
         fpAddPkg::sEmpty: begin
            if (push) stateNext = fpAddPkg::sReady;
         end
         fpAddPkg::sReady: begin
            if (push && !pop) stateNext = fpAddPkg::sFull;
            else if (!push && pop) stateNext = fpAddPkg::sEmpty;
         end
         fpAddPkg::sFull: begin
            if (pop && !push) stateNext = fpAddPkg::sReady;
         end
         default: stateNext = fpAddPkg::sEmpty;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= fpAddPkg::sEmpty;
         wrPtr <= 1'b0;
         rdPtr <= 1'b0;
      end else begin
         state <= stateNext;
         if (push) wrPtr <= wrPtr + 1'b1;
         if (pop) rdPtr <= rdPtr + 1'b1;
      end
   end

   // Buffer payload
   always_ff @(posedge clk) begin
      if (push) begin
         bufOp[wrPtr] <= opCode;
         bufA[wrPtr]  <= opA;
         bufB[wrPtr]  <= opB;
      end
   end

endmodule

/* logic/fpAlign.sv */
`timescale 1ns/1ps
//**********************************************************
// Stage 1: unpack, special detection, magnitude swap, alignment
// Ends with the magnitude add or subtract, registered on advance
//**********************************************************
module fpAlign (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        advance,
   input  logic                        issueValid,
   input  fpAddPkg::fpOp               issueOp,
   input  logic [fpAddPkg::WORD_W-1:0] issueA,
   input  logic [fpAddPkg::WORD_W-1:0] issueB,
   output logic                        s1Valid,
   output logic                        s1Sign,
   output logic [fpAddPkg::EXP_W-1:0]  s1Exp,
   output logic [fpAddPkg::SIG_W-1:0]  s1Mant,
   output logic                        s1Special,
   output logic [fpAddPkg::WORD_W-1:0] s1SpecialResult,
   output logic                        s1Invalid
);

   // Unpacked fields, B sign already flipped for opSub
   logic                         aSign;
   logic                         bSign;
   logic [fpAddPkg::EXP_W-1:0]   aExp;
   logic [fpAddPkg::EXP_W-1:0]   bExp;
   logic [fpAddPkg::MANT_W-1:0]  aFrac;
   logic [fpAddPkg::MANT_W-1:0]  bFrac;
   logic                         aNan;
   logic                         bNan;
   logic                         aInf;
   logic                         bInf;
   logic                         infDiff;
   logic                         effSub;
   logic                         swap;
   logic                         bigSign;
   logic [fpAddPkg::EXP_W-1:0]   bigRaw;
   logic [fpAddPkg::EXP_W-1:0]   smallRaw;
   logic [fpAddPkg::EXP_W-1:0]   bigExp;
   logic [fpAddPkg::EXP_W-1:0]   smallExp;
   logic [fpAddPkg::MANT_W:0]    bigSig;
   logic [fpAddPkg::MANT_W:0]    smallSig;
   logic [fpAddPkg::EXP_W-1:0]   expDiff;
   logic [5:0]                   shiftAmt;
   logic [2*fpAddPkg::SUM_W-1:0] shiftWide;
   logic [fpAddPkg::SUM_W-1:0]   bigExt;
   logic [fpAddPkg::SUM_W-1:0]   alignSig;
   logic [fpAddPkg::SUM_W-1:0]   sum;
   logic                         earlyNorm;

   assign aSign = issueA[fpAddPkg::WORD_W-1];
   assign bSign = issueB[fpAddPkg::WORD_W-1] ^ (issueOp == fpAddPkg::opSub);
   assign aExp  = issueA[fpAddPkg::WORD_W-2:fpAddPkg::MANT_W];
   assign bExp  = issueB[fpAddPkg::WORD_W-2:fpAddPkg::MANT_W];
   assign aFrac = issueA[fpAddPkg::MANT_W-1:0];
   assign bFrac = issueB[fpAddPkg::MANT_W-1:0];

   // Special input classes
   assign aNan    = (aExp == fpAddPkg::EXP_INF) && (aFrac != '0);
   assign bNan    = (bExp == fpAddPkg::EXP_INF) && (bFrac != '0);
   assign aInf    = (aExp == fpAddPkg::EXP_INF) && (aFrac == '0);
   assign bInf    = (bExp == fpAddPkg::EXP_INF) && (bFrac == '0);
   assign effSub  = aSign ^ bSign;
   assign infDiff = aInf && bInf && effSub;

   // Packed magnitude order equals numeric order, subnormals included
   assign swap     = issueB[fpAddPkg::WORD_W-2:0] > issueA[fpAddPkg::WORD_W-2:0];
   assign bigSign  = swap ? bSign : aSign;
   assign bigRaw   = swap ? bExp : aExp;
   assign smallRaw = swap ? aExp : bExp;
   assign bigSig   = {bigRaw != '0, swap ? bFrac : aFrac};
   assign smallSig = {smallRaw != '0, swap ? aFrac : bFrac};

   // Subnormals sit at the minimum exponent without a hidden one
   assign bigExp   = (bigRaw == '0) ? fpAddPkg::EXP_MIN : bigRaw;
   assign smallExp = (smallRaw == '0) ? fpAddPkg::EXP_MIN : smallRaw;
   assign expDiff  = bigExp - smallExp;
   // Beyond 63 everything lands in the sticky bit anyway
   assign shiftAmt = (expDiff > 11'd63) ? 6'd63 : expDiff[5:0];

   // Right shift into a zero extension, lower half collapses to sticky
   assign bigExt    = {1'b0, bigSig, 3'b000};
   assign shiftWide = {1'b0, smallSig, 3'b000, {fpAddPkg::SUM_W{1'b0}}} >> shiftAmt;
   assign alignSig  = {shiftWide[2*fpAddPkg::SUM_W-1:fpAddPkg::SUM_W+1],
                       shiftWide[fpAddPkg::SUM_W] | (|shiftWide[fpAddPkg::SUM_W-1:0])};

   // Larger minus smaller never goes negative
   assign sum = effSub ? (bigExt - alignSig) : (bigExt + alignSig);

   // Far subtraction loses at most one bit, fix it here to keep the round bit
   // Near cases carry no round or sticky, so the shift is exact there
   assign earlyNorm = (sum[fpAddPkg::SUM_W-1 -: 2] == 2'b00) && (bigExp > fpAddPkg::EXP_MIN);

   always_ff @(posedge clk) begin
      if (reset) begin
         s1Valid <= 1'b0;
      end else if (advance) begin
         s1Valid <= issueValid;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         // Exact cancellation gives +0
         s1Sign <= (effSub && (sum == '0)) ? 1'b0 : bigSign;
         s1Exp  <= earlyNorm ? (bigExp - fpAddPkg::EXP_MIN) : bigExp;
         s1Mant <= earlyNorm ? sum[fpAddPkg::SUM_W-2:0]
                             : {sum[fpAddPkg::SUM_W-1:2], sum[1] | sum[0]};
         // NaN and infinity bypass normalize and round
         s1Special <= aNan || bNan || aInf || bInf;
         s1Invalid <= (aNan && !aFrac[fpAddPkg::MANT_W-1]) ||
                      (bNan && !bFrac[fpAddPkg::MANT_W-1]) || infDiff;
         s1SpecialResult <= (aNan || bNan || infDiff) ? fpAddPkg::QNAN
                          : {aInf ? aSign : bSign, fpAddPkg::EXP_INF,
                             {fpAddPkg::MANT_W{1'b0}}};
      end
   end

endmodule

/* logic/fpNormRound.sv */
`timescale 1ns/1ps
//**********************************************************
// Stage 2: normalize, round to nearest even, repack, flags
// Output register of the pipeline, held while advance is low
//**********************************************************
module fpNormRound (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        advance,
   input  logic                        s1Valid,
   input  logic                        s1Sign,
   input  logic [fpAddPkg::EXP_W-1:0]  s1Exp,
   input  logic [fpAddPkg::SIG_W-1:0]  s1Mant,
   input  logic                        s1Special,
   input  logic [fpAddPkg::WORD_W-1:0] s1SpecialResult,
   input  logic                        s1Invalid,
   output logic                        resValid,
   output logic [fpAddPkg::WORD_W-1:0] result,
   output logic [fpAddPkg::FLAG_W-1:0] flags
);

   logic                         carry;
   logic [5:0]                   lzCount;
   logic [fpAddPkg::EXP_W-1:0]   expRoom;
   logic [5:0]                   shiftAmt;
   logic [fpAddPkg::SIG_W-1:0]   normMant;
   logic [fpAddPkg::EXP_W:0]     normExp;
   logic [fpAddPkg::EXP_W:0]     expField;
   logic                         roundUp;
   logic [fpAddPkg::WORD_W-1:0]  rounded;
   logic                         overflow;
   logic [fpAddPkg::WORD_W-1:0]  resultNext;
   logic [fpAddPkg::FLAG_W-1:0]  flagsNext;

   // Carry out of the magnitude add
   assign carry = s1Mant[fpAddPkg::SIG_W-1];

   // Leading zeros below the carry position, all zero counts as full width
   always_comb begin
      lzCount = 6'(fpAddPkg::SIG_W - 1);
      for (int i = 0; i < fpAddPkg::SIG_W - 1; i++) begin
         if (s1Mant[i]) lzCount = 6'(fpAddPkg::SIG_W - 2 - i);
      end
   end

   // Left shift stops at the subnormal exponent
   assign expRoom  = s1Exp - fpAddPkg::EXP_MIN;
   assign shiftAmt = ({5'd0, lzCount} > expRoom) ? expRoom[5:0] : lzCount;

   // Carry case shifts right once and folds the lost bit into sticky
   assign normMant = carry ? {1'b0, s1Mant[fpAddPkg::SIG_W-1:2], s1Mant[1] | s1Mant[0]}
                           : (s1Mant << shiftAmt);
   assign normExp  = carry ? ({1'b0, s1Exp} + 1'b1)
                           : ({1'b0, s1Exp} - {6'd0, shiftAmt});

   // No hidden one left means a subnormal or zero, field is 0
   assign expField = normMant[fpAddPkg::SIG_W-2] ? normExp : '0;

   // Nearest even: guard set and either sticky or an odd LSB
   assign roundUp = normMant[1] & (normMant[0] | normMant[2]);

   // Round carry ripples into the exponent field
   // This covers mantissa overflow and subnormal to normal alike
   assign rounded  = {expField, normMant[fpAddPkg::SIG_W-3:2]} + 64'(roundUp);
   assign overflow = rounded[fpAddPkg::WORD_W-1:fpAddPkg::MANT_W] >= {1'b0, fpAddPkg::EXP_INF};

   // Result and flag selection
   always_comb begin
      flagsNext = '0;
      if (s1Special) begin
         resultNext = s1SpecialResult;
         flagsNext[fpAddPkg::FLAG_INVALID] = s1Invalid;
      end else if (overflow) begin
         // Signed infinity
         resultNext = {s1Sign, fpAddPkg::EXP_INF, {fpAddPkg::MANT_W{1'b0}}};
         flagsNext[fpAddPkg::FLAG_OVERFLOW] = 1'b1;
      end else begin
         resultNext = {s1Sign, rounded[fpAddPkg::WORD_W-2:0]};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         resValid <= 1'b0;
      end else if (advance) begin
         resValid <= s1Valid;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         result <= resultNext;
         flags  <= flagsNext;
      end
   end

endmodule

/* logic/fpAddTop.sv */
`timescale 1ns/1ps
//**********************************************************
// Top level of the credit-controlled binary64 adder/subtractor
// Buffer, two datapath stages and the output credit counter
//**********************************************************
module fpAddTop (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        opValid,
   input  fpAddPkg::fpOp               opCode,
   input  logic [fpAddPkg::WORD_W-1:0] opA,
   input  logic [fpAddPkg::WORD_W-1:0] opB,
   output logic                        inCredit,
   output logic                        resValid,
   output logic [fpAddPkg::WORD_W-1:0] result,
   output logic [fpAddPkg::FLAG_W-1:0] flags,
   input  logic                        resCredit
);

   logic                        haveCredit;
   logic                        advance;
   logic                        s2Valid;

   // Buffer to stage 1
   logic                        issueValid;
   fpAddPkg::fpOp               issueOp;
   logic [fpAddPkg::WORD_W-1:0] issueA;
   logic [fpAddPkg::WORD_W-1:0] issueB;

   // Stage 1 to stage 2
   logic                        s1Valid;
   logic                        s1Sign;
   logic [fpAddPkg::EXP_W-1:0]  s1Exp;
   logic [fpAddPkg::SIG_W-1:0]  s1Mant;
   logic                        s1Special;
   logic [fpAddPkg::WORD_W-1:0] s1SpecialResult;
   logic                        s1Invalid;

   // Finished result is presented only while an output credit is held
   assign resValid = s2Valid & haveCredit;

   fpAddControl uControl (
      .clk(clk), .reset(reset),
      .opValid(opValid), .opCode(opCode), .opA(opA), .opB(opB),
      .haveCredit(haveCredit), .s2Valid(s2Valid), .inCredit(inCredit),
      .issueValid(issueValid), .issueOp(issueOp), .issueA(issueA), .issueB(issueB),
      .advance(advance)
   );

   creditCounter uCredit (
      .clk(clk), .reset(reset),
      .sent(resValid), .resCredit(resCredit), .haveCredit(haveCredit)
   );

   fpAlign uAlign (
      .clk(clk), .reset(reset), .advance(advance),
      .issueValid(issueValid), .issueOp(issueOp), .issueA(issueA), .issueB(issueB),
      .s1Valid(s1Valid), .s1Sign(s1Sign), .s1Exp(s1Exp), .s1Mant(s1Mant),
      .s1Special(s1Special), .s1SpecialResult(s1SpecialResult), .s1Invalid(s1Invalid)
   );

   fpNormRound uNormRound (
      .clk(clk), .reset(reset), .advance(advance),
      .s1Valid(s1Valid), .s1Sign(s1Sign), .s1Exp(s1Exp), .s1Mant(s1Mant),
      .s1Special(s1Special), .s1SpecialResult(s1SpecialResult), .s1Invalid(s1Invalid),
      .resValid(s2Valid), .result(result), .flags(flags)
   );

endmodule

/* verif/fpAddChecks_sva.sv */
`timescale 1ns/1ps
//**********************************************************
// Concurrent checks on the credit and handshake rules
// Bound into fpAddTop, reports only through failing assertions
//**********************************************************
module fpAddChecks (
   input logic                          clk,
   input logic                          reset,
   input logic                          resValid,
   input logic                          resCredit,
   input logic                          haveCredit,
   input logic                          s2Valid,
   input logic                          inCredit,
   input logic                          s1Valid,
   input logic [fpAddPkg::WORD_W-1:0]   result,
   input logic [fpAddPkg::CREDIT_W-1:0] creditCount
);

   // Each sent result uses up one held output credit
   resultSpendsCredit: assert property (@(posedge clk) disable iff (reset)
      (resValid && !resCredit) |=> (creditCount == $past(creditCount) - 1'b1))
      else $error("sent result did not use up an output credit");

   // Input credit goes back only for an entry that enters stage 1
   creditOnlyOnIssue: assert property (@(posedge clk) disable iff (reset)
      inCredit |=> s1Valid)
      else $error("inCredit pulsed without an entry reaching stage 1");

   // Stalled result waits in stage 2 unchanged
   stalledResultHeld: assert property (@(posedge clk) disable iff (reset)
      (s2Valid && !haveCredit) |=> (s2Valid && $stable(result)))
      else $error("stalled result was dropped or changed");

   // Returned credit never finds the counter already full
   creditBound: assert property (@(posedge clk) disable iff (reset)
      resCredit |-> (creditCount < fpAddPkg::OUT_CREDITS))
      else $error("output credit returned above the initial allotment");

endmodule

bind fpAddTop fpAddChecks uChecks (
   .clk(clk), .reset(reset), .resValid(resValid), .resCredit(resCredit),
   .haveCredit(haveCredit), .s2Valid(s2Valid), .inCredit(inCredit),
   .s1Valid(s1Valid), .result(result), .creditCount(uCredit.count)
);

/* verif/fpAddTb.sv */
`timescale 1ns/1ps
//**********************************************************
// Random testbench for fpAddTop against a real-arithmetic model
// Credit-aware producer, random consumer, results checked in order
//**********************************************************
module fpAddTb;

   localparam int          WAIT_LIMIT = 2000;
   localparam logic [63:0] CANON_NAN  = 64'h7FF8_0000_0000_0000;

   logic          clk = 1'b0;
   logic          reset;
   logic          opValid;
   fpAddPkg::fpOp opCode;
   logic [63:0]   opA;
   logic [63:0]   opB;
   logic          resCredit = 1'b0;
   logic          inCredit;
   logic          resValid;
   logic [63:0]   result;
   logic [1:0]    flags;

   // Expected values in send order, send cycle or -1 when latency is free
   logic [63:0] expResult [$];
   logic [1:0]  expFlags [$];
   int          expCycle [$];

   int cycleCnt = 0;
   int sentCount = 0;
   int inCreditsSeen = 0;
   int resultsSeen = 0;
   int creditsReturned = 0;
   int creditRate = 100;
   int sendAt;
   bit timed = 1'b1;

   fpAddTop UUT (
      .clk(clk), .reset(reset), .opValid(opValid), .opCode(opCode),
      .opA(opA), .opB(opB), .inCredit(inCredit), .resValid(resValid),
      .result(result), .flags(flags), .resCredit(resCredit)
   );

   always #5 clk = ~clk;

   always @(posedge clk) cycleCnt <= cycleCnt + 1;

   task automatic stopWithError(input string what);
      $display("ERROR at %0t: %s", $time, what);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic checkValue(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t: %s actual %h expected %h",
                  $time, name, actual, expected);
         $display("Simulation finished: FAIL");
         $fatal(1, "stopped at first error");
      end
   endtask

   function automatic bit isNan(input logic [63:0] v);
      return (v[62:52] == 11'h7FF) && (v[51:0] != '0);
   endfunction

   function automatic bit isInf(input logic [63:0] v);
      return (v[62:52] == 11'h7FF) && (v[51:0] == '0);
   endfunction

   // Reference sum, simulator doubles round to nearest even
   function automatic logic [65:0] modelAdd(input logic [63:0] a, input logic [63:0] b,
                                            input fpAddPkg::fpOp op);
      logic        bSign;
      logic [63:0] res;
      logic [1:0]  flg;
      real         sum;
      bSign = b[63] ^ (op == fpAddPkg::opSub);
      flg = '0;
      if (isNan(a) || isNan(b)) begin
         res = CANON_NAN;
         // Quiet bit clear marks a signaling NaN
         flg[fpAddPkg::FLAG_INVALID] = (isNan(a) && !a[51]) || (isNan(b) && !b[51]);
      end else if (isInf(a) && isInf(b) && (a[63] != bSign)) begin
         res = CANON_NAN;
         flg[fpAddPkg::FLAG_INVALID] = 1'b1;
      end else begin
         if (op == fpAddPkg::opSub) sum = $bitstoreal(a) - $bitstoreal(b);
         else sum = $bitstoreal(a) + $bitstoreal(b);
         res = $realtobits(sum);
         // Finite inputs rounding to infinity
         flg[fpAddPkg::FLAG_OVERFLOW] = !isInf(a) && !isInf(b) && isInf(res);
      end
      return {flg, res};
   endfunction

   // Operand of one class with random sign and fraction
   function automatic logic [63:0] randOperand(input int kind);
      logic [63:0] raw;
      logic [10:0] expo;
      logic [51:0] frac;
      raw = {$urandom, $urandom};
      frac = raw[51:0];
      case (kind)
         0: expo = 11'(990 + $urandom % 70);
         1: expo = 11'(1 + $urandom % 2046);
         2: begin
            // Subnormal of varying size
            expo = '0;
            frac = frac >> ($urandom % 52);
         end
         3: expo = 11'(1 + $urandom % 3);
         4: expo = 11'(2045 + $urandom % 2);
         5: begin
            expo = '0;
            frac = '0;
         end
         6: begin
            expo = '1;
            frac = '0;
         end
         default: begin
            // NaN, quiet bit left random
            expo = '1;
            frac[0] = 1'b1;
         end
      endcase
      return {raw[63], expo, frac};
   endfunction

   task automatic makePair(output logic [63:0] a, output logic [63:0] b,
                           output fpAddPkg::fpOp op);
      int          pick;
      logic [63:0] tmp;
      pick = $urandom % 100;
      op = ($urandom % 2 == 1) ? fpAddPkg::opSub : fpAddPkg::opAdd;
      a = randOperand(0);
      b = randOperand(0);
      if (pick < 25) begin
         // Nearby magnitudes under effective subtraction, x - x when untouched
         b = a;
         if (pick >= 3) b[31:0] = a[31:0] ^ ($urandom >> ($urandom % 32));
         if (pick >= 15) b[62:52] = a[62:52] - 11'd1;
         b[63] = a[63] ^ (op == fpAddPkg::opAdd);
      end else if (pick < 40) begin
         a = randOperand(2);
         b = randOperand((pick < 32) ? 2 : 3);
      end else if (pick < 50) begin
         a = randOperand(4);
         b = randOperand(4);
      end else if (pick < 80) begin
         // Zero, infinity or NaN against a mixed partner
         a = randOperand(5 + pick % 3);
         b = randOperand((pick < 65) ? 1 : pick % 8);
      end else if (pick < 92) begin
         a = randOperand(1);
         b = randOperand(1);
      end
      if ($urandom % 2 == 1) begin
         tmp = a;
         a = b;
         b = tmp;
      end
   endtask

   // Drives one operation as soon as an input credit is held
   task automatic sendOp(input logic [63:0] a, input logic [63:0] b,
                         input fpAddPkg::fpOp op);
      int          waited;
      logic [65:0] model;
      waited = 0;
      while (fpAddPkg::IN_CREDITS + inCreditsSeen - sentCount <= 0) begin
         opValid = 1'b0;
         @(posedge clk);
         #1;
         waited++;
         if (waited > WAIT_LIMIT) stopWithError("timed out waiting for an input credit");
      end
      model = modelAdd(a, b, op);
      expResult.push_back(model[63:0]);
      expFlags.push_back(model[65:64]);
      expCycle.push_back(timed ? cycleCnt : -1);
      opValid = 1'b1;
      opCode = op;
      opA = a;
      opB = b;
      sentCount++;
      @(posedge clk);
      #1;
      opValid = 1'b0;
   endtask

   // Waits until every result is out and every output credit is back
   task automatic drain();
      int waited;
      waited = 0;
      while ((resultsSeen != sentCount) || (creditsReturned != resultsSeen)) begin
         @(posedge clk);
         #1;
         waited++;
         if (waited > WAIT_LIMIT) stopWithError("timed out waiting for results to drain");
      end
      @(posedge clk);
      #1;
   endtask

   // Mid-cycle sampling of credits and results
   always @(negedge clk) begin
      if (!reset) begin
         if (inCredit) inCreditsSeen++;
         if (resValid) begin
            if (expResult.size() == 0) stopWithError("result with no operation outstanding");
            resultsSeen++;
            if (resultsSeen > int'(fpAddPkg::OUT_CREDITS) + creditsReturned)
               stopWithError("more results than output credits allow");
            checkValue("result", result, expResult.pop_front());
            checkValue("flags", 64'(flags), 64'(expFlags.pop_front()));
            sendAt = expCycle.pop_front();
            if (sendAt >= 0) checkValue("latency", 64'(cycleCnt - sendAt), 64'd3);
         end
      end
   end

   // Consumer frees results at a random rate
   always @(posedge clk) begin
      #1;
      if (!reset && (resultsSeen > creditsReturned) && ($urandom % 100 < creditRate)) begin
         resCredit = 1'b1;
         creditsReturned++;
      end else begin
         resCredit = 1'b0;
      end
   end

   initial begin
      logic [63:0]   a;
      logic [63:0]   b;
      fpAddPkg::fpOp op;
      void'($urandom(81714));
      reset = 1'b1;
      opValid = 1'b0;
      opCode = fpAddPkg::opAdd;
      opA = '0;
      opB = '0;
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;

      // Corner cases with free credits, latency checked
      sendOp(64'h3FF8_0000_0000_0000, 64'h3FF8_0000_0000_0000, fpAddPkg::opSub);
      sendOp(64'h7FEF_FFFF_FFFF_FFFF, 64'h7FEF_FFFF_FFFF_FFFF, fpAddPkg::opAdd);
      sendOp(64'hFFEF_FFFF_FFFF_FFFF, 64'h7FEF_FFFF_FFFF_FFFF, fpAddPkg::opSub);
      sendOp(64'h7FF0_0000_0000_0000, 64'h7FF0_0000_0000_0000, fpAddPkg::opSub);
      sendOp(64'h7FF0_0000_0000_0001, 64'h3FF0_0000_0000_0000, fpAddPkg::opAdd);
      sendOp(64'h7FF8_0000_0000_0000, 64'h3FF0_0000_0000_0000, fpAddPkg::opAdd);
      sendOp(64'h0010_0000_0000_0000, 64'h000F_FFFF_FFFF_FFFF, fpAddPkg::opSub);
      sendOp(64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, fpAddPkg::opAdd);
      for (int i = 0; i < 300; i++) begin
         makePair(a, b, op);
         sendOp(a, b, op);
      end
      drain();

      // Back-pressure with idle gaps, latency free
      timed = 1'b0;
      creditRate = 20;
      for (int i = 0; i < 1500; i++) begin
         makePair(a, b, op);
         if ($urandom % 4 == 0) begin
            @(posedge clk);
            #1;
         end
         sendOp(a, b, op);
      end
      drain();

      // Every issued entry returned its input credit
      checkValue("inCredit count", 64'(inCreditsSeen), 64'(sentCount));
      checkValue("pending results", 64'(expResult.size()), 64'd0);
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

/* fpAdd.f */
logic/fpAddPkg.sv
logic/creditCounter.sv
logic/fpAddControl.sv
logic/fpAlign.sv
logic/fpNormRound.sv
logic/fpAddTop.sv
verif/fpAddChecks_sva.sv
verif/fpAddTb.sv

/* Makefile */
# Verilator flow for the binary64 add/sub pipeline
# Override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= fpAddTb
FILELIST  ?= fpAdd.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message missing from $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
